/* build.f */
+incdir+design
design/mmu_pkg.sv
design/mmu_tlb.sv
design/mmu_walk_arbiter.sv
design/mmu_ptw.sv
design/mmu_fetch_xlate.sv
design/mmu_data_xlate.sv
design/mmu_top.sv
sim/mmu_tb.sv

/* design/mmu_cfg.svh */
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// --------------------------------------------------
// sv39 address geometry
// --------------------------------------------------
// virtual address width
`define MMU_VLEN 39
// physical address width
`define MMU_PLEN 56
// physical page number width
`define MMU_PPNW 44

// --------------------------------------------------
// tlb and walker sizing
// --------------------------------------------------
// entries per tlb, one tlb per translation path
`define MMU_TLB_ENTRIES 4
// page table levels walked, root first
`define MMU_LEVELS 3
// bytes per page table entry
`define MMU_PTE_BYTES 8

`endif

/* design/mmu_data_xlate.sv */
`timescale 1ns/100ps
`include "mmu_cfg.svh"

module mmu_data_xlate import mmu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      enable_translation_i,
  input  logic      lsu_req_i,
  input  logic      lsu_is_store_i,
  input  logic      sum_i,
  input  vaddr_t    lsu_vaddr_i,
  input  priv_lvl_t ld_st_priv_lvl_i,
  input  tlb_rsp_t  dtlb_rsp_i,
  input  walk_rsp_t walk_rsp_i,
  output walk_req_t walk_req_o,
  output logic      lsu_dtlb_hit_o,
  output ppn_t      lsu_dtlb_ppn_o,
  output logic      lsu_valid_o,
  output paddr_t    lsu_paddr_o,
  output exc_t      lsu_exc_o
);

  // request cycle state, used one cycle later
  logic     valid_q;
  logic     xlate_q;
  logic     store_q;
  vaddr_t   vaddr_q;
  tlb_rsp_t rsp_q;
  paddr_t   early_paddr;
  logic     priv_err;
  logic     perm_err;

  // --------------------------------------------------
  // request cycle
  // --------------------------------------------------
  assign lsu_dtlb_hit_o = lsu_req_i && (!enable_translation_i || dtlb_rsp_i.hit);
  assign early_paddr    = enable_translation_i
                          ? merge_paddr(dtlb_rsp_i.pte.ppn, lsu_vaddr_i,
                                        dtlb_rsp_i.is_2m, dtlb_rsp_i.is_1g)
                          : paddr_t'(lsu_vaddr_i);
  assign lsu_dtlb_ppn_o = early_paddr[`MMU_PLEN-1:12];

  // miss under translation goes to the walker
  assign walk_req_o.valid = lsu_req_i && enable_translation_i && !dtlb_rsp_i.hit;
  assign walk_req_o.vaddr = lsu_vaddr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= lsu_dtlb_hit_o;
    end
  end

  always_ff @(posedge clk_i) begin
    xlate_q <= enable_translation_i;
    store_q <= lsu_is_store_i;
    vaddr_q <= lsu_vaddr_i;
    rsp_q   <= dtlb_rsp_i;
  end

  // --------------------------------------------------
  // response cycle
  // --------------------------------------------------
  // u page from s mode needs sum, s page from u mode never
  assign priv_err = ((ld_st_priv_lvl_i == PRIV_LVL_S) && rsp_q.pte.u && !sum_i)
                    || ((ld_st_priv_lvl_i == PRIV_LVL_U) && !rsp_q.pte.u);
  // stores need w and d, loads need r
  assign perm_err = store_q ? (!rsp_q.pte.w || !rsp_q.pte.d) : !rsp_q.pte.r;

  always_comb begin
    lsu_valid_o = valid_q;
    lsu_paddr_o = xlate_q ? merge_paddr(rsp_q.pte.ppn, vaddr_q, rsp_q.is_2m, rsp_q.is_1g)
                          : paddr_t'(vaddr_q);
    lsu_exc_o   = '0;
    if (valid_q && xlate_q && (priv_err || perm_err)) begin
      lsu_exc_o.valid = 1'b1;
      lsu_exc_o.cause = store_q ? EXC_STORE_PAGE_FAULT : EXC_LOAD_PAGE_FAULT;
      lsu_exc_o.tval  = 64'(vaddr_q);
    end else if (walk_rsp_i.done && walk_rsp_i.error) begin
      // walk fault ends the request in the done cycle
      lsu_valid_o     = 1'b1;
      lsu_exc_o.valid = 1'b1;
      lsu_exc_o.cause = store_q ? EXC_STORE_PAGE_FAULT : EXC_LOAD_PAGE_FAULT;
      lsu_exc_o.tval  = 64'(walk_rsp_i.vaddr);
    end
  end

endmodule

/* design/mmu_fetch_xlate.sv */
`timescale 1ns/100ps
`include "mmu_cfg.svh"

module mmu_fetch_xlate import mmu_pkg::*; (
  input  logic      enable_translation_i,
  input  logic      fetch_req_i,
  input  vaddr_t    fetch_vaddr_i,
  input  priv_lvl_t priv_lvl_i,
  input  tlb_rsp_t  itlb_rsp_i,
  input  walk_rsp_t walk_rsp_i,
  output walk_req_t walk_req_o,
  output logic      fetch_valid_o,
  output paddr_t    fetch_paddr_o,
  output exc_t      fetch_exc_o
);

  logic canonical;
  logic priv_err;

  // top two vaddr bits must agree for a canonical fetch
  assign canonical = (fetch_vaddr_i[`MMU_VLEN-1] == fetch_vaddr_i[`MMU_VLEN-2]);
  // u pages for user mode only, s pages for supervisor only
  assign priv_err  = ((priv_lvl_i == PRIV_LVL_U) && !itlb_rsp_i.pte.u)
                     || ((priv_lvl_i == PRIV_LVL_S) && itlb_rsp_i.pte.u);

  always_comb begin
    // translation off, address passes through
    fetch_valid_o = fetch_req_i;
    fetch_paddr_o = paddr_t'(fetch_vaddr_i);
    fetch_exc_o   = '0;
    walk_req_o    = '0;
    if (enable_translation_i) begin
      fetch_valid_o = 1'b0;
      fetch_paddr_o = merge_paddr(itlb_rsp_i.pte.ppn, fetch_vaddr_i,
                                  itlb_rsp_i.is_2m, itlb_rsp_i.is_1g);
      if (fetch_req_i && !canonical) begin
        // no walk for a bad address
        fetch_valid_o     = 1'b1;
        fetch_exc_o.valid = 1'b1;
        fetch_exc_o.cause = EXC_INSTR_ACCESS_FAULT;
        fetch_exc_o.tval  = 64'(fetch_vaddr_i);
      end else if (itlb_rsp_i.hit) begin
        fetch_valid_o = fetch_req_i;
        if (!itlb_rsp_i.pte.x || priv_err) begin
          fetch_exc_o.valid = 1'b1;
          fetch_exc_o.cause = EXC_INSTR_PAGE_FAULT;
          fetch_exc_o.tval  = 64'(fetch_vaddr_i);
        end
      end else begin
        // itlb miss, ask for a walk
        walk_req_o.valid = fetch_req_i;
        walk_req_o.vaddr = fetch_vaddr_i;
        if (walk_rsp_i.done && walk_rsp_i.error) begin
          fetch_valid_o     = 1'b1;
          fetch_exc_o.valid = 1'b1;
          fetch_exc_o.cause = EXC_INSTR_PAGE_FAULT;
          fetch_exc_o.tval  = 64'(walk_rsp_i.vaddr);
        end
      end
    end
  end

endmodule

/* design/mmu_pkg.sv */
`include "mmu_cfg.svh"

package mmu_pkg;

  typedef logic [`MMU_VLEN-1:0]    vaddr_t;
  typedef logic [`MMU_PLEN-1:0]    paddr_t;
  typedef logic [`MMU_PPNW-1:0]    ppn_t;
  // three 9-bit vpn fields
  typedef logic [`MMU_VLEN-13:0]   vpn_t;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // sv39 pte, msb first
  typedef struct packed {
    logic [9:0] rsvd;
    ppn_t       ppn;
    logic [1:0] rsw;
    logic       d;
    logic       a;
    logic       g;
    logic       u;
    logic       x;
    logic       w;
    logic       r;
    logic       v;
  } pte_t;

  typedef struct packed {
    logic valid;
    vpn_t vpn;
    pte_t pte;
    logic is_2m;
    logic is_1g;
  } tlb_entry_t;

  typedef struct packed {
    logic hit;
    pte_t pte;
    logic is_2m;
    logic is_1g;
  } tlb_rsp_t;

  typedef enum logic [3:0] {
    EXC_INSTR_ACCESS_FAULT = 4'd1,
    EXC_INSTR_PAGE_FAULT   = 4'd12,
    EXC_LOAD_PAGE_FAULT    = 4'd13,
    EXC_STORE_PAGE_FAULT   = 4'd15
  } exc_cause_t;

  // tval is the faulting vaddr, zero extended
  typedef struct packed {
    logic        valid;
    exc_cause_t  cause;
    logic [63:0] tval;
  } exc_t;

  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
  } walk_req_t;

  typedef struct packed {
    logic       done;
    logic       error;
    vaddr_t     vaddr;
    tlb_entry_t entry;
  } walk_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    WAIT,
    DONE
  } ptw_state_t;

  // superpages take the low vpn fields straight from the vaddr
  function automatic paddr_t merge_paddr(ppn_t ppn, vaddr_t vaddr, logic is_2m, logic is_1g);
    paddr_t paddr;
    paddr = {ppn, vaddr[11:0]};
    if (is_2m) begin
      paddr[20:12] = vaddr[20:12];
    end
    if (is_1g) begin
      paddr[29:12] = vaddr[29:12];
    end
    return paddr;
  endfunction

endpackage

/* design/mmu_ptw.sv */
`timescale 1ns/100ps
`include "mmu_cfg.svh"

module mmu_ptw import mmu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  walk_req_t walk_req_i,
  input  ppn_t      satp_ppn_i,
  output walk_rsp_t walk_rsp_o,
  output logic      mem_req_o,
  output paddr_t    mem_addr_o,
  input  logic      mem_rvalid_i,
  input  pte_t      mem_rdata_i
);

  ptw_state_t state_q;
  logic [1:0] level_q;
  vaddr_t     vaddr_q;
  ppn_t       ppn_q;
  pte_t       pte_q;
  logic       err_q;
  logic       is_2m_q;
  logic       is_1g_q;
  logic [8:0] vpn_idx;
  logic       pte_leaf;
  logic       pte_fault;

  // vpn field of the current level
  assign vpn_idx    = vaddr_q[12 + 9 * level_q +: 9];
  assign mem_req_o  = (state_q == READ);
  assign mem_addr_o = {ppn_q, 12'h000} + paddr_t'(vpn_idx) * paddr_t'(`MMU_PTE_BYTES);

  // --------------------------------------------------
  // pte decode
  // --------------------------------------------------
  always_comb begin
    pte_leaf  = mem_rdata_i.r || mem_rdata_i.x;
    // invalid, or write without read
    pte_fault = !mem_rdata_i.v || (mem_rdata_i.w && !mem_rdata_i.r);
    if (pte_leaf) begin
      if (!mem_rdata_i.a) begin
        pte_fault = 1'b1;
      end
      // misaligned superpage
      if (level_q == 2'd2 && mem_rdata_i.ppn[17:0] != '0) begin
        pte_fault = 1'b1;
      end
      if (level_q == 2'd1 && mem_rdata_i.ppn[8:0] != '0) begin
        pte_fault = 1'b1;
      end
    end else if (level_q == 2'd0) begin
      // pointer at the last level
      pte_fault = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      level_q <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (walk_req_i.valid) begin
            state_q <= READ;
            level_q <= 2'(`MMU_LEVELS - 1);
          end
        end
        READ: state_q <= WAIT;
        WAIT: begin
          if (mem_rvalid_i) begin
            if (pte_fault || pte_leaf) begin
              state_q <= DONE;
            end else begin
              state_q <= READ;
              level_q <= level_q - 1'b1;
            end
          end
        end
        DONE: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // walk payload, root from satp then each pointer pte
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && walk_req_i.valid) begin
      vaddr_q <= walk_req_i.vaddr;
      ppn_q   <= satp_ppn_i;
    end
    if (state_q == WAIT && mem_rvalid_i) begin
      ppn_q   <= mem_rdata_i.ppn;
      pte_q   <= mem_rdata_i;
      err_q   <= pte_fault;
      is_1g_q <= (level_q == 2'd2);
      is_2m_q <= (level_q == 2'd1);
    end
  end

  always_comb begin
    walk_rsp_o             = '0;
    walk_rsp_o.done        = (state_q == DONE);
    walk_rsp_o.error       = err_q;
    walk_rsp_o.vaddr       = vaddr_q;
    walk_rsp_o.entry.valid = !err_q;
    walk_rsp_o.entry.vpn   = vaddr_q[`MMU_VLEN-1:12];
    walk_rsp_o.entry.pte   = pte_q;
    walk_rsp_o.entry.is_2m = is_2m_q;
    walk_rsp_o.entry.is_1g = is_1g_q;
  end

  // read data only comes back while the walker waits for it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i |-> (state_q == WAIT))
    else $error("memory read data outside WAIT");

endmodule

/* design/mmu_tlb.sv */
`timescale 1ns/100ps
`include "mmu_cfg.svh"

module mmu_tlb import mmu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  input  logic      lu_access_i,
  input  vaddr_t    lu_vaddr_i,
  input  walk_rsp_t update_i,
  output tlb_rsp_t  lu_rsp_o
);

  localparam int unsigned N    = `MMU_TLB_ENTRIES;
  localparam int unsigned IdxW = (N > 1) ? $clog2(N) : 1;

  logic [N-1:0]    valid_q;
  tlb_entry_t      entry_q [N];
  logic [N-1:0]    match;
  logic [IdxW-1:0] victim_q;
  vpn_t            lu_vpn;

  assign lu_vpn = lu_vaddr_i[`MMU_VLEN-1:12];

  // --------------------------------------------------
  // lookup
  // --------------------------------------------------
  // low vpn fields are don't care for superpages
  always_comb begin
    lu_rsp_o = '0;
    for (int i = 0; i < N; i++) begin
      match[i] = valid_q[i] && (entry_q[i].vpn[26:18] == lu_vpn[26:18])
                 && (entry_q[i].is_1g || (entry_q[i].vpn[17:9] == lu_vpn[17:9]))
                 && (entry_q[i].is_1g || entry_q[i].is_2m
                     || (entry_q[i].vpn[8:0] == lu_vpn[8:0]));
      if (lu_access_i && match[i]) begin
        lu_rsp_o.hit   = 1'b1;
        lu_rsp_o.pte   = entry_q[i].pte;
        lu_rsp_o.is_2m = entry_q[i].is_2m;
        lu_rsp_o.is_1g = entry_q[i].is_1g;
      end
    end
  end

  // --------------------------------------------------
  // refill and flush
  // --------------------------------------------------
  // round robin victim, moves on every refill
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (update_i.done) begin
      valid_q[victim_q] <= update_i.entry.valid;
      victim_q          <= (victim_q == IdxW'(N - 1)) ? '0 : victim_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_i.done && !flush_i) begin
      entry_q[victim_q] <= update_i.entry;
    end
  end

  // a walk only starts on a miss, so entries never overlap
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lu_access_i |-> $onehot0(match))
    else $error("tlb lookup matched more than one entry");

  // walker must not finish while the tlb is being flushed
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(flush_i && update_i.done))
    else $error("tlb refill in the flush cycle");

endmodule

/* design/mmu_top.sv */
`timescale 1ns/100ps

module mmu_top import mmu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      enable_translation_i,
  input  logic      flush_tlb_i,
  input  ppn_t      satp_ppn_i,
  input  priv_lvl_t priv_lvl_i,
  input  priv_lvl_t ld_st_priv_lvl_i,
  input  logic      sum_i,
  // fetch side
  input  logic      fetch_req_i,
  input  vaddr_t    fetch_vaddr_i,
  output logic      fetch_valid_o,
  output paddr_t    fetch_paddr_o,
  output exc_t      fetch_exc_o,
  // load/store side
  input  logic      lsu_req_i,
  input  logic      lsu_is_store_i,
  input  vaddr_t    lsu_vaddr_i,
  output logic      lsu_dtlb_hit_o,
  output ppn_t      lsu_dtlb_ppn_o,
  output logic      lsu_valid_o,
  output paddr_t    lsu_paddr_o,
  output exc_t      lsu_exc_o,
  // page table memory
  output logic      mem_req_o,
  output paddr_t    mem_addr_o,
  input  logic      mem_rvalid_i,
  input  pte_t      mem_rdata_i
);

  tlb_rsp_t  itlb_rsp, dtlb_rsp;
  walk_req_t ireq, dreq, walk_req;
  walk_rsp_t walk_rsp, itlb_update, dtlb_update, irsp, drsp;

  mmu_tlb i_itlb (
    .clk_i, .rst_ni, .flush_i(flush_tlb_i), .lu_access_i(fetch_req_i),
    .lu_vaddr_i(fetch_vaddr_i), .update_i(itlb_update), .lu_rsp_o(itlb_rsp)
  );

  mmu_tlb i_dtlb (
    .clk_i, .rst_ni, .flush_i(flush_tlb_i), .lu_access_i(lsu_req_i),
    .lu_vaddr_i(lsu_vaddr_i), .update_i(dtlb_update), .lu_rsp_o(dtlb_rsp)
  );

  mmu_walk_arbiter i_arbiter (
    .clk_i, .rst_ni, .ireq_i(ireq), .dreq_i(dreq), .walk_req_o(walk_req),
    .walk_rsp_i(walk_rsp), .itlb_update_o(itlb_update), .dtlb_update_o(dtlb_update),
    .irsp_o(irsp), .drsp_o(drsp)
  );

  mmu_ptw i_ptw (
    .clk_i, .rst_ni, .walk_req_i(walk_req), .satp_ppn_i, .walk_rsp_o(walk_rsp),
    .mem_req_o, .mem_addr_o, .mem_rvalid_i, .mem_rdata_i
  );

  mmu_fetch_xlate i_fetch (
    .enable_translation_i, .fetch_req_i, .fetch_vaddr_i, .priv_lvl_i,
    .itlb_rsp_i(itlb_rsp), .walk_rsp_i(irsp), .walk_req_o(ireq),
    .fetch_valid_o, .fetch_paddr_o, .fetch_exc_o
  );

  mmu_data_xlate i_data (
    .clk_i, .rst_ni, .enable_translation_i, .lsu_req_i, .lsu_is_store_i, .sum_i,
    .lsu_vaddr_i, .ld_st_priv_lvl_i, .dtlb_rsp_i(dtlb_rsp), .walk_rsp_i(drsp),
    .walk_req_o(dreq), .lsu_dtlb_hit_o, .lsu_dtlb_ppn_o, .lsu_valid_o,
    .lsu_paddr_o, .lsu_exc_o
  );

endmodule

/* design/mmu_walk_arbiter.sv */
`timescale 1ns/100ps

module mmu_walk_arbiter import mmu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  walk_req_t ireq_i,
  input  walk_req_t dreq_i,
  output walk_req_t walk_req_o,
  input  walk_rsp_t walk_rsp_i,
  output walk_rsp_t itlb_update_o,
  output walk_rsp_t dtlb_update_o,
  output walk_rsp_t irsp_o,
  output walk_rsp_t drsp_o
);

  // owner of the walk in progress
  logic busy_q;
  logic owner_d_q;

  // grant only while the walker idles, data side wins
  always_comb begin
    walk_req_o = '0;
    if (!busy_q) begin
      walk_req_o = dreq_i.valid ? dreq_i : ireq_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      owner_d_q <= 1'b0;
    end else if (!busy_q && walk_req_o.valid) begin
      busy_q    <= 1'b1;
      owner_d_q <= dreq_i.valid;
    end else if (walk_rsp_i.done) begin
      busy_q <= 1'b0;
    end
  end

  // --------------------------------------------------
  // steer the response by owner
  // --------------------------------------------------
  // translators see every result, tlbs only clean ones
  always_comb begin
    irsp_o             = walk_rsp_i;
    drsp_o             = walk_rsp_i;
    irsp_o.done        = walk_rsp_i.done && busy_q && !owner_d_q;
    drsp_o.done        = walk_rsp_i.done && busy_q && owner_d_q;
    itlb_update_o      = irsp_o;
    dtlb_update_o      = drsp_o;
    itlb_update_o.done = irsp_o.done && !walk_rsp_i.error;
    dtlb_update_o.done = drsp_o.done && !walk_rsp_i.error;
  end

  // walker and arbiter must agree on when a walk is open
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    walk_rsp_i.done |-> busy_q)
    else $error("walk finished without an owner");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the mmu testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module mmu_tb -o mmu_sim \
  || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/mmu_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qF "=== PASS ===" && exit 0 || exit 1

/* sim/mmu_tb.sv */
`timescale 1ns/100ps

module mmu_tb import mmu_pkg::*; ();

  // longest wait for any one result, in clock cycles
  localparam int unsigned TIMEOUT_CYCLES = 200;

  logic      clk_i;
  logic      rst_ni;
  logic      enable_translation_i;
  logic      flush_tlb_i;
  ppn_t      satp_ppn_i;
  priv_lvl_t priv_lvl_i;
  priv_lvl_t ld_st_priv_lvl_i;
  logic      sum_i;
  logic      fetch_req_i;
  vaddr_t    fetch_vaddr_i;
  logic      fetch_valid_o;
  paddr_t    fetch_paddr_o;
  exc_t      fetch_exc_o;
  logic      lsu_req_i;
  logic      lsu_is_store_i;
  vaddr_t    lsu_vaddr_i;
  logic      lsu_dtlb_hit_o;
  ppn_t      lsu_dtlb_ppn_o;
  logic      lsu_valid_o;
  paddr_t    lsu_paddr_o;
  exc_t      lsu_exc_o;
  logic      mem_req_o;
  paddr_t    mem_addr_o;
  logic      mem_rvalid_i;
  pte_t      mem_rdata_i;

  // sparse page table, words never written read back as zero
  logic [63:0] pt_mem [paddr_t];
  int unsigned error_count;
  logic        req_seen;
  paddr_t      addr_seen;

  mmu_top mmu_top_i (.*);

  always #50 clk_i = ~clk_i;

  // --------------------------------------------------
  // page table memory, answers one cycle after the strobe
  // --------------------------------------------------
  always begin
    @(negedge clk_i);
    req_seen  = mem_req_o;
    addr_seen = mem_addr_o;
    @(posedge clk_i);
    #10;
    mem_rvalid_i = req_seen;
    mem_rdata_i  = pte_t'(read_page_table(addr_seen));
  end

  function automatic logic [63:0] read_page_table(paddr_t addr);
    if (pt_mem.exists(addr)) begin
      return pt_mem[addr];
    end
    return 64'h0;
  endfunction

  // inputs change 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_true(logic cond, string what);
    assert (cond) else begin
      $display("%s (at %0t)", what, $time);
      error_count++;
    end
  endtask

  // clean result compares the paddr, a fault compares cause and tval
  task automatic check_result(string side, vaddr_t va, paddr_t pa, exc_t exc,
                              paddr_t pa_exp, logic [3:0] cause_exp);
    if (cause_exp == 4'd0) begin
      check_value({side, "_exc_o.valid"}, 64'(exc.valid), 64'd0);
      check_value({side, "_paddr_o"}, 64'(pa), 64'(pa_exp));
    end else begin
      check_value({side, "_exc_o.valid"}, 64'(exc.valid), 64'd1);
      check_value({side, "_exc_o.cause"}, 64'(exc.cause), 64'(cause_exp));
      check_value({side, "_exc_o.tval"}, exc.tval, 64'(va));
    end
  endtask

  // --------------------------------------------------
  // fetch, held until fetch_valid_o
  // --------------------------------------------------
  task automatic run_fetch(vaddr_t va, logic walk_exp, paddr_t pa_exp, logic [3:0] cause_exp);
    int unsigned cycles;
    logic        saw_mem;
    logic        got;
    paddr_t      pa;
    exc_t        exc;
    cycles        = 0;
    saw_mem       = 1'b0;
    got           = 1'b0;
    pa            = '0;
    exc           = '0;
    fetch_req_i   = 1'b1;
    fetch_vaddr_i = va;
    while (!got && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      saw_mem = saw_mem || mem_req_o;
      if (fetch_valid_o) begin
        got = 1'b1;
        pa  = fetch_paddr_o;
        exc = fetch_exc_o;
      end else begin
        cycles++;
        next_cycle();
      end
    end
    check_true(got, "fetch timed out waiting for fetch_valid_o");
    if (got) begin
      if (walk_exp) begin
        check_true(saw_mem, "fetch completed without a page table read");
      end else begin
        check_true(cycles == 0, "fetch did not complete in its request cycle");
      end
      check_result("fetch", va, pa, exc, pa_exp, cause_exp);
    end
    next_cycle();
    fetch_req_i = 1'b0;
  endtask

  // --------------------------------------------------
  // load or store, re-presented until lsu_valid_o
  // --------------------------------------------------
  task automatic run_data_access(vaddr_t va, logic is_store, logic walk_exp,
                                 paddr_t pa_exp, logic [3:0] cause_exp);
    int unsigned cycles;
    logic        saw_mem;
    logic        got;
    logic        hit_first;
    logic        hit_after_walk;
    logic        prev_hit;
    ppn_t        ppn_at_hit;
    paddr_t      pa;
    exc_t        exc;
    cycles         = 0;
    saw_mem        = 1'b0;
    got            = 1'b0;
    hit_first      = 1'b0;
    hit_after_walk = 1'b0;
    prev_hit       = 1'b0;
    ppn_at_hit     = '0;
    pa             = '0;
    exc            = '0;
    lsu_req_i      = 1'b1;
    lsu_is_store_i = is_store;
    lsu_vaddr_i    = va;
    while (!got && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      saw_mem = saw_mem || mem_req_o;
      if (lsu_valid_o) begin
        got = 1'b1;
        pa  = lsu_paddr_o;
        exc = lsu_exc_o;
      end else begin
        if (cycles == 0) begin
          hit_first = lsu_dtlb_hit_o;
        end
        // early ppn of the hit that the response follows
        if (lsu_dtlb_hit_o) begin
          ppn_at_hit = lsu_dtlb_ppn_o;
        end
        hit_after_walk = hit_after_walk || (saw_mem && lsu_dtlb_hit_o);
        prev_hit       = lsu_dtlb_hit_o;
        cycles++;
        next_cycle();
      end
    end
    check_true(got, "data access timed out waiting for lsu_valid_o");
    if (got) begin
      if (walk_exp) begin
        check_true(saw_mem, "data access completed without a page table read");
        if (cause_exp == 4'd0) begin
          check_true(hit_after_walk, "lsu_dtlb_hit_o stayed low on the retry after the walk");
        end
      end else begin
        check_true(hit_first, "lsu_dtlb_hit_o was low in the request cycle");
      end
      if (cause_exp == 4'd0) begin
        check_true(prev_hit, "lsu_valid_o did not come one cycle after a hit");
        check_value("lsu_dtlb_ppn_o", 64'(ppn_at_hit), 64'(pa_exp >> 12));
      end
      check_result("lsu", va, pa, exc, pa_exp, cause_exp);
    end
    next_cycle();
    lsu_req_i      = 1'b0;
    lsu_is_store_i = 1'b0;
  endtask

  // --------------------------------------------------
  // vector sequencer
  // --------------------------------------------------
  initial begin
    int          fd;
    int          test_count;
    int          fail_count;
    int unsigned errors_before;
    int unsigned gap;
    string       line;
    string       rest;
    byte         kind;
    logic [63:0] f0, f1, f2, f3, f4, f5;
    clk_i                = 1'b0;
    rst_ni               = 1'b0;
    enable_translation_i = 1'b0;
    flush_tlb_i          = 1'b0;
    satp_ppn_i           = ppn_t'(44'h80000);
    priv_lvl_i           = PRIV_LVL_S;
    ld_st_priv_lvl_i     = PRIV_LVL_S;
    sum_i                = 1'b0;
    fetch_req_i          = 1'b0;
    fetch_vaddr_i        = '0;
    lsu_req_i            = 1'b0;
    lsu_is_store_i       = 1'b0;
    lsu_vaddr_i          = '0;
    mem_rvalid_i         = 1'b0;
    mem_rdata_i          = '0;
    error_count          = 0;
    test_count           = 0;
    fail_count           = 0;
    void'($urandom(88));
    repeat (10) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_true(!fetch_valid_o && !lsu_valid_o && !lsu_dtlb_hit_o && !mem_req_o
               && !fetch_exc_o.valid && !lsu_exc_o.valid,
               "an output was high right after reset");
    next_cycle();
    fd = $fopen("sim/mmu_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open sim/mmu_vectors.txt");
      error_count++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        kind = (line.len() > 0) ? line.getc(0) : "#";
        rest = (line.len() > 2) ? line.substr(2, line.len() - 1) : "";
        f0   = '0;
        f1   = '0;
        f2   = '0;
        f3   = '0;
        f4   = '0;
        f5   = '0;
        void'($sscanf(rest, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5));
        errors_before = error_count;
        case (kind)
          "P": pt_mem[paddr_t'(f0)] = f1;
          "E": begin
            enable_translation_i = f0[0];
            next_cycle();
          end
          "X": begin
            flush_tlb_i = 1'b1;
            next_cycle();
            flush_tlb_i = 1'b0;
            next_cycle();
          end
          "F": begin
            priv_lvl_i = priv_lvl_t'(f0[1:0]);
            sum_i      = f1[0];
            run_fetch(vaddr_t'(f3), f2[0], paddr_t'(f4), f5[3:0]);
          end
          "L", "S": begin
            ld_st_priv_lvl_i = priv_lvl_t'(f0[1:0]);
            sum_i            = f1[0];
            run_data_access(vaddr_t'(f3), kind == "S", f2[0], paddr_t'(f4), f5[3:0]);
          end
          "C": begin
            priv_lvl_i       = priv_lvl_t'(f0[1:0]);
            ld_st_priv_lvl_i = priv_lvl_t'(f0[1:0]);
            sum_i            = 1'b0;
            // both misses raised in the same cycle
            fork
              run_fetch(vaddr_t'(f1), 1'b1, paddr_t'(f2), 4'd0);
              run_data_access(vaddr_t'(f3), 1'b0, 1'b1, paddr_t'(f4), 4'd0);
            join
          end
          default: ;
        endcase
        if (kind == "F" || kind == "L" || kind == "S" || kind == "C") begin
          test_count++;
          if (error_count != errors_before) begin
            fail_count++;
          end
          $display("test %0d %c %h: %0d errors", test_count, kind,
                   (kind == "C") ? f1 : f3, error_count - errors_before);
          gap = 1 + ($urandom % 4);
          repeat (gap) next_cycle();
        end
      end
      $fclose(fd);
    end
    $display("%0d tests, %0d failed, %0d check errors", test_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* sim/mmu_vectors.txt */
# P paddr pte | E enable | X flush | C priv fetch_va fetch_pa load_va load_pa
# F/L/S priv sum walk vaddr paddr cause (walk 1 expects a table walk, cause 0 no fault)
P 80000000 20000401
P 80000008 300000c7
P 80001000 20000801
P 80001008 240800c7
P 80002008 2200044b
P 80002010 22000847
P 80002018 22000cd7
P 80002020 220010c7
P 80002030 2200184b
P 80002038 22001cc7
E 0
F 1 0 0 12345 12345 0
L 1 0 0 7654321 7654321 0
E 1
F 1 0 1 1004 88001004 0
F 1 0 0 1abc 88001abc 0
L 1 0 1 234567 90234567 0
L 1 0 1 4abcdef0 cabcdef0 0
S 1 0 1 2010 0 f
L 1 0 1 3008 0 d
L 1 1 0 3008 88003008 0
F 1 0 1 4000 0 c
F 1 0 0 4000000000 0 1
F 1 0 1 5000 0 c
L 1 0 1 5008 0 d
C 1 6010 88006010 7020 88007020
X
F 1 0 1 1008 88001008 0
